// ==== hw/cpuPkg.sv ====
package cpuPkg;

    // Datapath and instruction field widths
    localparam int WORD_W    = 32;
    localparam int REG_IDX_W = 4;
    localparam int IMM_W     = 12;
    localparam int OP_W      = 4;
    localparam int KIND_W    = 2;
    localparam int VEC_W     = 5;  // Throw vector number, low bits of the word

    // Operand order, top two bits of the instruction
    typedef enum logic [KIND_W-1:0] {
        KIND_XYI   = 2'd0,  // A=X, B=Y, C=I
        KIND_XIY   = 2'd1,  // A=X, B=I, C=Y
        KIND_IXY   = 2'd2,  // A=I, B=X, C=Y
        KIND_THROW = 2'd3
    } insnKind_e;

    typedef enum logic [OP_W-1:0] {
        ALU_OR   = 4'd0,
        ALU_AND  = 4'd1,
        ALU_ADD  = 4'd2,
        ALU_MUL  = 4'd3,
        ALU_RSVD = 4'd4,   // Result undefined
        ALU_SHL  = 4'd5,
        ALU_LT   = 4'd6,
        ALU_EQ   = 4'd7,
        ALU_GE   = 4'd8,
        ALU_ANDN = 4'd9,
        ALU_XOR  = 4'd10,
        ALU_SUB  = 4'd11,
        ALU_XNOR = 4'd12,
        ALU_SHR  = 4'd13,
        ALU_NE   = 4'd14,
        ALU_SRA  = 4'd15
    } aluOp_e;

    localparam logic [REG_IDX_W-1:0] REG_ZERO = 4'd0;
    localparam logic [REG_IDX_W-1:0] REG_P    = 4'd15;  // Reads as next instruction address

    typedef enum logic [3:0] {
        ST_IDLE      = 4'd0,
        ST_EXEC0     = 4'd1,
        ST_EXEC1     = 4'd2,
        ST_EXEC2     = 4'd3,
        ST_EXEC3     = 4'd4,
        ST_EXEC4     = 4'd5,
        ST_EXEC5     = 4'd6,
        ST_EXEC6     = 4'd7,
        ST_EXEC7     = 4'd8,
        ST_THROW     = 4'd9,
        ST_TRAP      = 4'd10,
        ST_READVEC   = 4'd11,
        ST_SAVE      = 4'd12,
        ST_WRITESAVE = 4'd13
    } coreState_e;

endpackage

// ==== hw/memMapPkg.sv ====
package memMapPkg;

    // First instruction fetched after leaving idle
    localparam logic [31:0] RESET_VECTOR = 32'h0000_0100;

    // External trap entry point
    localparam logic [31:0] TRAP_TRAMPOLINE = 32'h0000_0080;

    // Both throw and trap leave the interrupted address here
    localparam logic [31:0] TRAP_SAVE_ADDR = 32'h0000_007F;

    // Handler table, vector number goes into the low 5 bits
    localparam logic [31:0] VECTOR_BASE = 32'h0000_0040;

endpackage

// ==== hw/regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input  logic                           clk,
    input  logic                           writeEn,
    input  logic [cpuPkg::REG_IDX_W-1:0]   idxZ,
    input  logic [cpuPkg::REG_IDX_W-1:0]   idxX,
    input  logic [cpuPkg::REG_IDX_W-1:0]   idxY,
    input  logic [cpuPkg::WORD_W-1:0]      nextZ,
    input  logic [cpuPkg::WORD_W-1:0]      nextP,
    output logic [cpuPkg::WORD_W-1:0]      valZ,
    output logic [cpuPkg::WORD_W-1:0]      valX,
    output logic [cpuPkg::WORD_W-1:0]      valY
);

    logic [cpuPkg::WORD_W-1:0] regs [1:14];  // Only general registers have storage

    function automatic logic [cpuPkg::WORD_W-1:0] readReg(
        input logic [cpuPkg::REG_IDX_W-1:0] idx
    );
        if (idx == cpuPkg::REG_ZERO) return '0;
        else if (idx == cpuPkg::REG_P) return nextP;
        else return regs[idx];
    endfunction

    always_comb begin
        valZ = readReg(idxZ);
        valX = readReg(idxX);
        valY = readReg(idxY);
    end

    // Jumps to P are taken by the core, not stored here
    always_ff @(posedge clk) begin
        if (writeEn && idxZ != cpuPkg::REG_ZERO && idxZ != cpuPkg::REG_P)
            regs[idxZ] <= nextZ;
    end

endmodule

// ==== hw/insnDecode.sv ====
`timescale 1ns/1ps

module insnDecode (
    input  logic [cpuPkg::WORD_W-1:0]    insn,
    output logic [cpuPkg::REG_IDX_W-1:0] idxZ,
    output logic [cpuPkg::REG_IDX_W-1:0] idxX,
    output logic [cpuPkg::REG_IDX_W-1:0] idxY,
    output logic [cpuPkg::WORD_W-1:0]    imm,
    output cpuPkg::aluOp_e               op,
    output cpuPkg::insnKind_e            kind,
    output logic                         storing,
    output logic                         derefRhs,
    output logic                         isThrow,
    output logic                         isJump,
    output logic [cpuPkg::VEC_W-1:0]     vector
);

    logic [cpuPkg::KIND_W-1:0] kindBits;
    logic [cpuPkg::OP_W-1:0]   opBits;
    logic [cpuPkg::IMM_W-1:0]  immBits;

    // kind | store | deref | Z | X | Y | op | imm
    assign {kindBits, storing, derefRhs, idxZ, idxX, idxY, opBits, immBits} = insn;

    assign kind = cpuPkg::insnKind_e'(kindBits);
    assign op   = cpuPkg::aluOp_e'(opBits);
    assign imm  = {{(cpuPkg::WORD_W - cpuPkg::IMM_W){immBits[cpuPkg::IMM_W-1]}}, immBits};

    assign isThrow = kind == cpuPkg::KIND_THROW;
    assign isJump  = idxZ == cpuPkg::REG_P && !storing;  // Writing P redirects fetch
    assign vector  = insn[cpuPkg::VEC_W-1:0];

endmodule

// ==== hw/operandShuffle.sv ====
`timescale 1ns/1ps

module operandShuffle (
    input  logic                      clk,
    input  logic                      en,
    input  cpuPkg::insnKind_e         kind,
    input  logic [cpuPkg::WORD_W-1:0] valX,
    input  logic [cpuPkg::WORD_W-1:0] valY,
    input  logic [cpuPkg::WORD_W-1:0] imm,
    output logic [cpuPkg::WORD_W-1:0] opA,
    output logic [cpuPkg::WORD_W-1:0] opB,
    output logic [cpuPkg::WORD_W-1:0] opC
);

    always_ff @(posedge clk) begin
        if (en) begin
            case (kind)
                cpuPkg::KIND_XYI: begin
                    opA <= valX;
                    opB <= valY;
                    opC <= imm;
                end
                cpuPkg::KIND_XIY: begin
                    opA <= valX;
                    opB <= imm;
                    opC <= valY;
                end
                cpuPkg::KIND_IXY: begin
                    opA <= imm;
                    opB <= valX;
                    opC <= valY;
                end
                default: begin  // Throw never reaches the ALU
                    opA <= 'x;
                    opB <= 'x;
                    opC <= 'x;
                end
            endcase
        end
    end

endmodule

// ==== hw/aluExec.sv ====
`timescale 1ns/1ps

module aluExec (
    input  logic                             clk,
    input  logic                             en,
    input  cpuPkg::aluOp_e                   op,
    input  logic signed [cpuPkg::WORD_W-1:0] opA,
    input  logic signed [cpuPkg::WORD_W-1:0] opB,
    input  logic signed [cpuPkg::WORD_W-1:0] opC,
    output logic        [cpuPkg::WORD_W-1:0] result
);

    logic signed [cpuPkg::WORD_W-1:0] opResult;

    // Comparisons give all ones for true, zero for false
    always_comb begin
        case (op)
            cpuPkg::ALU_OR:   opResult = opA | opB;
            cpuPkg::ALU_AND:  opResult = opA & opB;
            cpuPkg::ALU_ADD:  opResult = opA + opB;
            cpuPkg::ALU_MUL:  opResult = opA * opB;  // Low word of product
            cpuPkg::ALU_SHL:  opResult = opA << opB;
            cpuPkg::ALU_LT:   opResult = {cpuPkg::WORD_W{opA < opB}};
            cpuPkg::ALU_EQ:   opResult = {cpuPkg::WORD_W{opA == opB}};
            cpuPkg::ALU_GE:   opResult = {cpuPkg::WORD_W{opA >= opB}};
            cpuPkg::ALU_ANDN: opResult = opA & ~opB;
            cpuPkg::ALU_XOR:  opResult = opA ^ opB;
            cpuPkg::ALU_SUB:  opResult = opA - opB;
            cpuPkg::ALU_XNOR: opResult = opA ~^ opB;
            cpuPkg::ALU_SHR:  opResult = opA >> opB;   // Zero fill
            cpuPkg::ALU_NE:   opResult = {cpuPkg::WORD_W{opA != opB}};
            cpuPkg::ALU_SRA:  opResult = opA >>> opB;  // Sign fill
            default:          opResult = 'x;           // Reserved opcode
        endcase
    end

    // Addend C applies to every op, comparisons included
    always_ff @(posedge clk) begin
        if (en)
            result <= opResult + opC;
    end

endmodule

// ==== hw/cpuCore.sv ====
`timescale 1ns/1ps

module cpuCore (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      halt,
    input  logic                      trap,
    input  logic [cpuPkg::WORD_W-1:0] instrData,
    input  logic [cpuPkg::WORD_W-1:0] dataIn,
    output logic                      idle,
    output logic [cpuPkg::WORD_W-1:0] instrAddr,
    output logic                      dataStrobe,
    output logic                      dataWrite,
    output logic [cpuPkg::WORD_W-1:0] dataAddr,
    output logic [cpuPkg::WORD_W-1:0] dataOut
);

    cpuPkg::coreState_e state;

    logic [cpuPkg::WORD_W-1:0]    insn, nextP, resultReg, loadData, vecAddr;
    logic [cpuPkg::REG_IDX_W-1:0] idxZ, idxX, idxY;
    logic [cpuPkg::WORD_W-1:0]    imm, valZ, valX, valY, opA, opB, opC, aluResult, nextZ;
    logic [cpuPkg::VEC_W-1:0]     vector;
    cpuPkg::aluOp_e               op;
    cpuPkg::insnKind_e            kind;
    logic                         storing, derefRhs, isThrow, isJump, loading, writeEn;

    // Sequencing
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= cpuPkg::ST_IDLE;
        end else begin
            case (state)
                cpuPkg::ST_IDLE:      state <= halt ? cpuPkg::ST_IDLE : cpuPkg::ST_EXEC6;
                cpuPkg::ST_EXEC0: begin
                    if (halt)         state <= cpuPkg::ST_IDLE;   // Instruction dropped
                    else if (trap)    state <= cpuPkg::ST_TRAP;
                    else if (isThrow) state <= cpuPkg::ST_THROW;
                    else              state <= cpuPkg::ST_EXEC1;
                end
                cpuPkg::ST_EXEC1:     state <= cpuPkg::ST_EXEC2;
                cpuPkg::ST_EXEC2:     state <= cpuPkg::ST_EXEC3;
                cpuPkg::ST_EXEC3:     state <= cpuPkg::ST_EXEC4;
                cpuPkg::ST_EXEC4:     state <= cpuPkg::ST_EXEC5;
                cpuPkg::ST_EXEC5:     state <= cpuPkg::ST_EXEC6;
                cpuPkg::ST_EXEC6:     state <= cpuPkg::ST_EXEC7;
                cpuPkg::ST_EXEC7:     state <= cpuPkg::ST_EXEC0;
                cpuPkg::ST_THROW:     state <= cpuPkg::ST_READVEC;
                cpuPkg::ST_READVEC:   state <= cpuPkg::ST_SAVE;
                cpuPkg::ST_TRAP:      state <= cpuPkg::ST_SAVE;
                cpuPkg::ST_SAVE:      state <= cpuPkg::ST_WRITESAVE;
                cpuPkg::ST_WRITESAVE: state <= cpuPkg::ST_EXEC6;
                default:              state <= cpuPkg::ST_IDLE;
            endcase
        end
    end

    // Datapath registers, one update per state
    always_ff @(posedge clk) begin
        case (state)
            cpuPkg::ST_IDLE:    instrAddr <= memMapPkg::RESET_VECTOR;
            cpuPkg::ST_EXEC2:   resultReg <= aluResult;
            cpuPkg::ST_EXEC4:   loadData  <= dataIn;
            cpuPkg::ST_EXEC5:   instrAddr <= isJump ? nextZ : nextP;
            cpuPkg::ST_EXEC6:   nextP     <= instrAddr + 1'b1;
            cpuPkg::ST_EXEC7:   insn      <= instrData;  // Fetched word is valid now
            cpuPkg::ST_THROW:
                resultReg <= memMapPkg::VECTOR_BASE
                           | {{(cpuPkg::WORD_W - cpuPkg::VEC_W){1'b0}}, vector};
            cpuPkg::ST_READVEC: vecAddr   <= dataIn;     // Handler address from table
            cpuPkg::ST_TRAP:    vecAddr   <= memMapPkg::TRAP_TRAMPOLINE;
            cpuPkg::ST_SAVE:    resultReg <= instrAddr;  // Address of interrupted insn
            cpuPkg::ST_WRITESAVE: instrAddr <= vecAddr;
            default: ;
        endcase
    end

    insnDecode decode (
        .insn     (insn),
        .idxZ     (idxZ),
        .idxX     (idxX),
        .idxY     (idxY),
        .imm      (imm),
        .op       (op),
        .kind     (kind),
        .storing  (storing),
        .derefRhs (derefRhs),
        .isThrow  (isThrow),
        .isJump   (isJump),
        .vector   (vector)
    );

    operandShuffle shuffle (
        .clk  (clk),
        .en   (state == cpuPkg::ST_EXEC0),
        .kind (kind),
        .valX (valX),
        .valY (valY),
        .imm  (imm),
        .opA  (opA),
        .opB  (opB),
        .opC  (opC)
    );

    aluExec alu (
        .clk    (clk),
        .en     (state == cpuPkg::ST_EXEC1),
        .op     (op),
        .opA    (opA),
        .opB    (opB),
        .opC    (opC),
        .result (aluResult)
    );

    // Memory port, deref swaps the roles of Z and the result
    assign loading    = derefRhs && !storing;
    assign dataStrobe = (state == cpuPkg::ST_EXEC4 && (storing || loading))
                     || state == cpuPkg::ST_WRITESAVE;
    assign dataWrite  = (state == cpuPkg::ST_EXEC4 && storing)
                     || state == cpuPkg::ST_WRITESAVE;

    always_comb begin
        dataAddr = derefRhs ? resultReg : valZ;
        dataOut  = derefRhs ? valZ : resultReg;
        case (state)
            cpuPkg::ST_READVEC:   dataAddr = resultReg;
            cpuPkg::ST_WRITESAVE: begin
                dataAddr = memMapPkg::TRAP_SAVE_ADDR;
                dataOut  = resultReg;
            end
            default: ;
        endcase
    end

    // Writeback on EXEC5 unless storing
    assign nextZ   = derefRhs ? loadData : resultReg;
    assign writeEn = state == cpuPkg::ST_EXEC5 && !storing;
    assign idle    = state == cpuPkg::ST_IDLE;

    regFile regs (
        .clk     (clk),
        .writeEn (writeEn),
        .idxZ    (idxZ),
        .idxX    (idxX),
        .idxY    (idxY),
        .nextZ   (nextZ),
        .nextP   (nextP),
        .valZ    (valZ),
        .valX    (valX),
        .valY    (valY)
    );

endmodule

// ==== hw/wordMemory.sv ====
`timescale 1ns/1ps

module wordMemory #(
    parameter int MEM_WORDS = 1024
) (
    input  logic        clk,
    input  logic [31:0] instrAddr,
    output logic [31:0] instrData,
    input  logic        dataStrobe,
    input  logic        dataWrite,
    input  logic [31:0] dataAddr,
    input  logic [31:0] dataOut,
    output logic [31:0] dataIn,
    input  logic        loadEn,
    input  logic [31:0] loadAddr,
    input  logic [31:0] loadData
);

    localparam int ADDR_W = $clog2(MEM_WORDS);

    logic [31:0] mem [0:MEM_WORDS-1];

    // Addresses wrap around the array size
    function automatic logic [ADDR_W-1:0] wrap(input logic [31:0] addr);
        return ADDR_W'(addr % MEM_WORDS);
    endfunction

    // Fetch port, one cycle latency
    always_ff @(posedge clk) begin
        instrData <= mem[wrap(instrAddr)];
    end

    assign dataIn = mem[wrap(dataAddr)];  // Zero wait read

    // Load port wins over a core write in the same cycle
    always_ff @(posedge clk) begin
        if (loadEn)
            mem[wrap(loadAddr)] <= loadData;
        else if (dataStrobe && dataWrite)
            mem[wrap(dataAddr)] <= dataOut;
    end

endmodule

// ==== hw/cpuTop.sv ====
`timescale 1ns/1ps

module cpuTop #(
    parameter int MEM_WORDS = 1024
) (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        halt,
    input  logic        trap,
    input  logic        loadEn,
    input  logic [31:0] loadAddr,
    input  logic [31:0] loadData,
    output logic        idle,
    output logic        busStrobe,
    output logic        busWrite,
    output logic [31:0] busAddr,
    output logic [31:0] busData
);

    logic [31:0] instrAddr;
    logic [31:0] instrData;
    logic [31:0] dataIn;

    // Bus monitor outputs are the core data port itself
    cpuCore core (
        .clk        (clk),
        .reset_n    (reset_n),
        .halt       (halt),
        .trap       (trap),
        .instrData  (instrData),
        .dataIn     (dataIn),
        .idle       (idle),
        .instrAddr  (instrAddr),
        .dataStrobe (busStrobe),
        .dataWrite  (busWrite),
        .dataAddr   (busAddr),
        .dataOut    (busData)
    );

    wordMemory #(
        .MEM_WORDS (MEM_WORDS)
    ) memory (
        .clk        (clk),
        .instrAddr  (instrAddr),
        .instrData  (instrData),
        .dataStrobe (busStrobe),
        .dataWrite  (busWrite),
        .dataAddr   (busAddr),
        .dataOut    (busData),
        .dataIn     (dataIn),
        .loadEn     (loadEn),
        .loadAddr   (loadAddr),
        .loadData   (loadData)
    );

endmodule

// ==== verif/cpuCore_props.sv ====
`timescale 1ns/1ps

module cpuCore_props (
    input logic               clk,
    input logic               reset_n,
    input cpuPkg::coreState_e state,
    input logic               idle,
    input logic               dataStrobe,
    input logic               dataWrite
);

    // A write always comes with a strobe
    writeHasStrobe: assert property (@(posedge clk) disable iff (!reset_n)
        dataWrite |-> dataStrobe)
        else $error("dataWrite high without dataStrobe");

    noStrobeIdle: assert property (@(posedge clk) disable iff (!reset_n)
        idle |-> !dataStrobe)
        else $error("dataStrobe while idle");

    // Earliest next strobe is a trap save seven cycles on
    oneStrobePerInsn: assert property (@(posedge clk) disable iff (!reset_n)
        (dataStrobe && state == cpuPkg::ST_EXEC4) |=> !dataStrobe [*6])
        else $error("second strobe within one instruction");

endmodule

bind cpuCore cpuCore_props props (
    .clk        (clk),
    .reset_n    (reset_n),
    .state      (state),
    .idle       (idle),
    .dataStrobe (dataStrobe),
    .dataWrite  (dataWrite)
);

// ==== verif/cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb;

    localparam int PROGRAM_INSNS = 201;  // Sum over all test programs
    localparam int CYCLE_LIMIT   = PROGRAM_INSNS * 14 + 3000;

    logic        clk, reset_n, halt, trap, loadEn;
    logic [31:0] loadAddr, loadData;
    logic        idle, busStrobe, busWrite;
    logic [31:0] busAddr, busData;
    logic [31:0] lfsrState = 32'h35e76c57;
    logic [31:0] wrAddrQ [$];
    logic [31:0] wrDataQ [$];
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    cpuTop #(.MEM_WORDS(1024)) uut (
        .clk (clk), .reset_n (reset_n), .halt (halt), .trap (trap),
        .loadEn (loadEn), .loadAddr (loadAddr), .loadData (loadData),
        .idle (idle), .busStrobe (busStrobe), .busWrite (busWrite),
        .busAddr (busAddr), .busData (busData)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Bus monitor
    always @(posedge clk) begin
        if (busStrobe && busWrite) begin
            wrAddrQ.push_back(busAddr);
            wrDataQ.push_back(busData);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not complete within %0d cycles", CYCLE_LIMIT);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic lfsrStep();
        logic fb;
        fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] randWord(input int nBits);
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < nBits; i++)
            w = {w[30:0], lfsrStep()};
        return w;
    endfunction

    // Reference ALU with signed comparisons that give all ones when true
    function automatic logic [31:0] aluModel(input int op, input logic [31:0] a, b);
        case (op)
            0:  return a | b;
            1:  return a & b;
            2:  return a + b;
            3:  return a * b;
            5:  return a << b;
            6:  return ($signed(a) < $signed(b)) ? 32'hFFFF_FFFF : 32'h0;
            7:  return (a == b) ? 32'hFFFF_FFFF : 32'h0;
            8:  return ($signed(a) >= $signed(b)) ? 32'hFFFF_FFFF : 32'h0;
            9:  return a & ~b;
            10: return a ^ b;
            11: return a - b;
            12: return ~(a ^ b);
            13: return a >> b;
            14: return (a != b) ? 32'hFFFF_FFFF : 32'h0;
            15: return 32'($signed(a) >>> b);
            default: return 32'h0;
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic loadWord(input logic [31:0] addr, data);
        @(posedge clk);
        loadEn   <= 1'b1;
        loadAddr <= addr;
        loadData <= data;
    endtask

    // kind | store | deref | Z | X | Y | op | imm
    task automatic loadInsn(input logic [31:0] addr, input logic [1:0] kind,
                            input logic st, dr, input logic [3:0] z, x, y, op,
                            input logic [11:0] imm);
        loadWord(addr, {kind, st, dr, z, x, y, op, imm});
    endtask

    task automatic loadJumpSelf(input logic [31:0] addr);
        loadInsn(addr, cpuPkg::KIND_XYI, 1'b0, 1'b0, cpuPkg::REG_P, 4'd0, 4'd0,
                 cpuPkg::ALU_OR, addr[11:0]);
    endtask

    // Stores imm to address 0 through the zero register
    task automatic loadStoreImm(input logic [31:0] addr, input logic [11:0] imm);
        loadInsn(addr, cpuPkg::KIND_XYI, 1'b1, 1'b0, 4'd0, 4'd0, 4'd0, cpuPkg::ALU_OR, imm);
    endtask

    task automatic runProgram(input int nWrites);
        @(posedge clk);
        loadEn <= 1'b0;
        wrAddrQ.delete();
        wrDataQ.delete();
        halt <= 1'b0;
        while (wrAddrQ.size() < nWrites) begin
            @(posedge clk);
            if (wrAddrQ.size() > 0)
                trap <= 1'b0;  // One trap entry is enough
        end
        halt <= 1'b1;
        @(posedge clk);
        while (!idle)
            @(posedge clk);
        checkValue("writeCount", 32'(wrAddrQ.size()), 32'(nWrites));
    endtask

    task automatic expectWrite(input int idx, input logic [31:0] addr, data);
        if (idx >= wrAddrQ.size()) begin
            errors++;
            $display("Bus write %0d never happened", idx);
        end else begin
            checkValue("busAddr", wrAddrQ[idx], addr);
            checkValue("busData", wrDataQ[idx], data);
        end
    endtask

    task automatic testReset();
        repeat (4) begin
            @(posedge clk);
            checkValue("idle", 32'(idle), 32'd1);
            checkValue("busStrobe", 32'(busStrobe), 32'd0);
        end
        loadStoreImm(memMapPkg::RESET_VECTOR, 12'h1A5);
        loadJumpSelf(memMapPkg::RESET_VECTOR + 32'd1);
        runProgram(1);
        expectWrite(0, 32'h0, 32'h1A5);
    endtask

    task automatic testAlu();
        logic [31:0] x, y, immExt, a, b, c;
        logic [11:0] imm;
        logic        shift;
        for (int op = 0; op < 16; op++) begin
            for (int k = 0; k < 3; k++) begin
                if (op == 4)
                    continue;  // Reserved opcode
                x      = randWord(32);
                y      = randWord(32);
                imm    = 12'(randWord(12));
                shift  = op == 5 || op == 13 || op == 15;
                if (shift && k == 0) y = y & 32'd31;        // Keep shift amounts in range
                if (shift && k == 1) imm = imm & 12'd31;
                if (shift && k == 2) x = x & 32'd31;
                immExt = {{20{imm[11]}}, imm};
                a = (k == 2) ? immExt : x;
                b = (k == 0) ? y : ((k == 1) ? immExt : x);
                c = (k == 0) ? immExt : y;
                loadWord(32'h200, x);
                loadWord(32'h201, y);
                loadInsn(32'h100, cpuPkg::KIND_XYI, 1'b0, 1'b1, 4'd1, 4'd0, 4'd0,
                         cpuPkg::ALU_OR, 12'h200);
                loadInsn(32'h101, cpuPkg::KIND_XYI, 1'b0, 1'b1, 4'd2, 4'd0, 4'd0,
                         cpuPkg::ALU_OR, 12'h201);
                loadInsn(32'h102, k[1:0], 1'b1, 1'b0, 4'd0, 4'd1, 4'd2, op[3:0], imm);
                loadJumpSelf(32'h103);
                runProgram(1);
                expectWrite(0, 32'h0, aluModel(op, a, b) + c);
            end
        end
    endtask

    task automatic testRegisters();
        loadInsn(32'h100, cpuPkg::KIND_XYI, 1'b0, 1'b0, 4'd0, 4'd0, 4'd0,
                 cpuPkg::ALU_OR, 12'h7FF);                   // Write to r0 is lost
        loadStoreImm(32'h101, 12'h003);
        loadInsn(32'h102, cpuPkg::KIND_XYI, 1'b1, 1'b0, 4'd0, cpuPkg::REG_P, 4'd0,
                 cpuPkg::ALU_OR, 12'h000);
        loadInsn(32'h103, cpuPkg::KIND_XYI, 1'b0, 1'b0, 4'd4, 4'd0, 4'd0,
                 cpuPkg::ALU_OR, 12'h250);
        loadInsn(32'h104, cpuPkg::KIND_XYI, 1'b0, 1'b0, 4'd5, 4'd0, 4'd0,
                 cpuPkg::ALU_OR, 12'hF00);
        loadInsn(32'h105, cpuPkg::KIND_XYI, 1'b1, 1'b0, 4'd4, 4'd5, 4'd0,
                 cpuPkg::ALU_OR, 12'h000);
        loadJumpSelf(32'h106);
        runProgram(3);
        expectWrite(0, 32'h0, 32'h3);
        expectWrite(1, 32'h0, 32'h103);
        expectWrite(2, 32'h250, 32'hFFFF_FF00);
    endtask

    task automatic testLoadJump();
        logic [31:0] w;
        w = randWord(32);
        loadWord(32'h260, w);
        loadInsn(32'h100, cpuPkg::KIND_XYI, 1'b0, 1'b1, 4'd6, 4'd0, 4'd0,
                 cpuPkg::ALU_OR, 12'h260);
        loadInsn(32'h101, cpuPkg::KIND_XYI, 1'b1, 1'b0, 4'd0, 4'd6, 4'd0,
                 cpuPkg::ALU_OR, 12'h000);
        loadInsn(32'h102, cpuPkg::KIND_XYI, 1'b0, 1'b0, cpuPkg::REG_P, 4'd0, 4'd0,
                 cpuPkg::ALU_OR, 12'h104);                   // Skips the next store
        loadStoreImm(32'h103, 12'h111);
        loadStoreImm(32'h104, 12'h222);
        loadJumpSelf(32'h105);
        runProgram(2);
        expectWrite(0, 32'h0, w);
        expectWrite(1, 32'h0, 32'h222);
    endtask

    task automatic testThrow();
        loadWord(memMapPkg::VECTOR_BASE | 32'd5, 32'h180);
        loadInsn(32'h100, cpuPkg::KIND_THROW, 1'b0, 1'b0, 4'd0, 4'd0, 4'd0,
                 cpuPkg::ALU_OR, 12'h005);
        loadStoreImm(32'h180, 12'h123);
        loadJumpSelf(32'h181);
        runProgram(2);
        expectWrite(0, memMapPkg::TRAP_SAVE_ADDR, 32'h100);  // Address of the throw itself
        expectWrite(1, 32'h0, 32'h123);
    endtask

    task automatic testTrap();
        loadJumpSelf(32'h100);
        loadStoreImm(memMapPkg::TRAP_TRAMPOLINE, 12'h5A5);
        loadJumpSelf(memMapPkg::TRAP_TRAMPOLINE + 32'd1);
        trap <= 1'b1;
        runProgram(2);
        expectWrite(0, memMapPkg::TRAP_SAVE_ADDR, 32'h100);
        expectWrite(1, 32'h0, 32'h5A5);
    endtask

    initial begin
        reset_n  = 1'b0;
        halt     = 1'b1;
        trap     = 1'b0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        repeat (16) @(posedge clk);
        reset_n <= 1'b1;
        testReset();
        testAlu();
        testRegisters();
        testLoadJump();
        testThrow();
        testTrap();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== sim.f ====
hw/cpuPkg.sv
hw/memMapPkg.sv
hw/regFile.sv
hw/insnDecode.sv
hw/operandShuffle.sv
hw/aluExec.sv
hw/cpuCore.sv
hw/wordMemory.sv
hw/cpuTop.sv
verif/cpuCore_props.sv
verif/cpuTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cpuTb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Simulation finished: PASS" $(LOG); then \
		echo "Run ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
